// ==== hdl/nnPkg.sv ====
package nnPkg;

	// ********************
	// Widths and sizes
	// ********************
	localparam int DATA_W       = 8;
	localparam int NUM_FEATURES = 15;
	localparam int NUM_HIDDEN   = 4;
	localparam int NUM_CLASSES  = 3;

	typedef logic signed [DATA_W-1:0] act_t;    // Activation or partial sum
	typedef logic signed [DATA_W-1:0] weight_t; // Weight or bias

	typedef logic [NUM_FEATURES*DATA_W-1:0] featureVec_t;
	typedef logic [NUM_HIDDEN*DATA_W-1:0]   hiddenVec_t;
	typedef logic [NUM_CLASSES*DATA_W-1:0]  classVec_t;
	typedef logic [1:0]                     classIdx_t;

	// ********************
	// Default tables
	// ********************
	// Word k sits at bits [k*DATA_W +: DATA_W], k = neuron*NUM_IN + input.
	// Concatenations therefore list the highest neuron and input first.
	localparam logic [NUM_HIDDEN*NUM_FEATURES*DATA_W-1:0] HIDDEN_WEIGHTS = {
		// Neuron 3, inputs 14..0
		8'h1d, 8'he3, 8'h07, 8'h5a, 8'hc9, 8'h13, 8'hf1, 8'h2b,
		8'hd7, 8'h0b, 8'h39, 8'he5, 8'h17, 8'hc3, 8'h29,
		// Neuron 2
		8'hf5, 8'h21, 8'hcd, 8'h0f, 8'h33, 8'he9, 8'h47, 8'hfb,
		8'h11, 8'hb5, 8'h27, 8'h09, 8'hdb, 8'h3d, 8'hef,
		// Neuron 1
		8'h05, 8'hd3, 8'h2f, 8'hf7, 8'h19, 8'h4b, 8'hc5, 8'h0d,
		8'he1, 8'h37, 8'hfd, 8'h23, 8'hb9, 8'h15, 8'h43,
		// Neuron 0
		8'hf6, 8'h04, 8'h2c, 8'h2f, 8'hdf, 8'hdc, 8'hfa, 8'hf5,
		8'hf6, 8'h06, 8'h5f, 8'h44, 8'h37, 8'hb9, 8'h22
	};

	localparam logic [NUM_HIDDEN*DATA_W-1:0] HIDDEN_BIASES = {
		8'hfc, 8'h0b, 8'h13, 8'h06 // Neurons 3..0
	};

	localparam logic [NUM_CLASSES*NUM_HIDDEN*DATA_W-1:0] OUT_WEIGHTS = {
		8'h0d, 8'hf3, 8'h25, 8'h07, // Class 2, inputs 3..0
		8'he7, 8'h1b, 8'h09, 8'h2d, // Class 1
		8'h31, 8'h05, 8'hed, 8'h17  // Class 0
	};

	localparam logic [NUM_CLASSES*DATA_W-1:0] OUT_BIASES = {
		8'h05, 8'hfd, 8'h0c // Classes 2..0
	};

endpackage

// ==== hdl/neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode
	import nnPkg::*;
#(
	parameter int                     NUM_IN  = NUM_FEATURES,
	parameter logic [NUM_IN*DATA_W-1:0] WEIGHTS = '0,
	parameter weight_t                BIAS    = '0
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [NUM_IN*DATA_W-1:0] inAct,
	output act_t                     outAct
);

	logic [NUM_IN*DATA_W-1:0] inReg; // Stage 1 capture
	act_t                     sumReg; // Stage 2 wrapped sum
	act_t                     sumComb;

	// ********************
	// Multiply-accumulate
	// ********************
	// Everything stays 8 bits wide, so each product keeps only its low
	// byte and the running sum wraps.
	always_comb
	begin
		sumComb = BIAS;
		for (int i = 0; i < NUM_IN; i++)
		begin
			sumComb = sumComb
				+ act_t'(inReg[i*DATA_W +: DATA_W]) * weight_t'(WEIGHTS[i*DATA_W +: DATA_W]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg  <= '0;
			sumReg <= '0;
			outAct <= '0;
		end
		else
		begin
			inReg  <= inAct;
			sumReg <= sumComb;
			if (sumReg[DATA_W-1]) // ReLU
				outAct <= '0;
			else
				outAct <= sumReg;
		end
	end

	// ********************
	// Checks
	// ********************
	aNonNegative: assert property (@(posedge clk) disable iff (reset)
		!outAct[DATA_W-1]);

endmodule

// ==== hdl/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer
	import nnPkg::*;
#(
	parameter int                             NUM_IN  = NUM_FEATURES,
	parameter int                             NUM_OUT = NUM_HIDDEN,
	parameter logic [NUM_OUT*NUM_IN*DATA_W-1:0] WEIGHTS = '0,
	parameter logic [NUM_OUT*DATA_W-1:0]        BIASES  = '0
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      inStrobe,
	input  logic [NUM_IN*DATA_W-1:0]  inAct,
	output logic                      outStrobe,
	output logic [NUM_OUT*DATA_W-1:0] outAct
);

	localparam int NODE_LAT = 3; // Capture, sum, ReLU

	logic [NODE_LAT-1:0] strobePipe;

	// ********************
	// Neuron row
	// ********************
	for (genvar n = 0; n < NUM_OUT; n++)
	begin : gNode
		neuronNode #(
			.NUM_IN  (NUM_IN),
			.WEIGHTS (WEIGHTS[n*NUM_IN*DATA_W +: NUM_IN*DATA_W]),
			.BIAS    (weight_t'(BIASES[n*DATA_W +: DATA_W]))
		) i_node (
			.clk    (clk),
			.reset  (reset),
			.inAct  (inAct), // Same vector for every node
			.outAct (outAct[n*DATA_W +: DATA_W])
		);
	end

	// Strobe follows the data through the node stages
	always_ff @(posedge clk)
	begin
		if (reset)
			strobePipe <= '0;
		else
			strobePipe <= {strobePipe[NODE_LAT-2:0], inStrobe};
	end

	assign outStrobe = strobePipe[NODE_LAT-1];

	aQuietAfterReset: assert property (@(posedge clk)
		reset |=> !outStrobe);

endmodule

// ==== hdl/classArgmax.sv ====
`timescale 1ns/1ps

module classArgmax
	import nnPkg::*;
#(
	parameter int NUM_IN = NUM_CLASSES
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      inStrobe,
	input  classVec_t inAct,
	output logic      outStrobe,
	output classIdx_t classIdx,
	output act_t      classScore,
	output classVec_t scores
);

	classIdx_t bestIdx;
	act_t      bestScore;

	// Strict compare keeps the lowest index on a tie
	always_comb
	begin
		bestIdx   = '0;
		bestScore = act_t'(inAct[DATA_W-1:0]);
		for (int i = 1; i < NUM_IN; i++)
		begin
			if (act_t'(inAct[i*DATA_W +: DATA_W]) > bestScore)
			begin
				bestIdx   = classIdx_t'(i);
				bestScore = act_t'(inAct[i*DATA_W +: DATA_W]);
			end
		end
	end

	// ********************
	// Result registers
	// ********************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outStrobe  <= 1'b0;
			classIdx   <= '0;
			classScore <= '0;
			scores     <= '0;
		end
		else
		begin
			outStrobe <= inStrobe;
			if (inStrobe)
			begin
				classIdx   <= bestIdx;
				classScore <= bestScore;
				scores     <= inAct; // Kept for inspection
			end
		end
	end

	aIdxInRange: assert property (@(posedge clk) disable iff (reset)
		outStrobe |-> (int'(classIdx) < NUM_IN));

endmodule

// ==== hdl/nnClassifier.sv ====
`timescale 1ns/1ps

module nnClassifier
	import nnPkg::*;
#(
	parameter logic [NUM_HIDDEN*NUM_FEATURES*DATA_W-1:0] HID_WEIGHTS = HIDDEN_WEIGHTS,
	parameter logic [NUM_HIDDEN*DATA_W-1:0]              HID_BIASES  = HIDDEN_BIASES,
	parameter logic [NUM_CLASSES*NUM_HIDDEN*DATA_W-1:0]  OUT_W       = OUT_WEIGHTS,
	parameter logic [NUM_CLASSES*DATA_W-1:0]             OUT_B       = OUT_BIASES
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        inStrobe,
	input  featureVec_t features,
	output logic        outStrobe,
	output classIdx_t   classIdx,
	output act_t        classScore,
	output classVec_t   scores
);

	hiddenVec_t hiddenAct;
	logic       hiddenStrobe;
	classVec_t  classAct;
	logic       classStrobe;

	// ********************
	// Pipeline, 3 + 3 + 1
	// ********************
	denseLayer #(
		.NUM_IN  (NUM_FEATURES),
		.NUM_OUT (NUM_HIDDEN),
		.WEIGHTS (HID_WEIGHTS),
		.BIASES  (HID_BIASES)
	) hiddenLayer (
		.clk       (clk),
		.reset     (reset),
		.inStrobe  (inStrobe),
		.inAct     (features),
		.outStrobe (hiddenStrobe),
		.outAct    (hiddenAct)
	);

	denseLayer #(
		.NUM_IN  (NUM_HIDDEN),
		.NUM_OUT (NUM_CLASSES),
		.WEIGHTS (OUT_W),
		.BIASES  (OUT_B)
	) outputLayer (
		.clk       (clk),
		.reset     (reset),
		.inStrobe  (hiddenStrobe),
		.inAct     (hiddenAct),
		.outStrobe (classStrobe),
		.outAct    (classAct)
	);

	classArgmax #(
		.NUM_IN (NUM_CLASSES)
	) argmaxUnit (
		.clk        (clk),
		.reset      (reset),
		.inStrobe   (classStrobe),
		.inAct      (classAct),
		.outStrobe  (outStrobe),
		.classIdx   (classIdx),
		.classScore (classScore),
		.scores     (scores)
	);

endmodule

// ==== sim/nnClassifierTb.sv ====
`timescale 1ns/1ps

module nnClassifierTb
	import nnPkg::*;
();

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 8;
	localparam int PIPE_LAT        = 7; // Drive cycle to visible outStrobe
	localparam int MAX_GAP         = 9;
	localparam int NUM_FIXED       = 5;
	localparam int NUM_RANDOM      = 12;
	localparam int NUM_TESTS       = NUM_FIXED + 2*NUM_RANDOM;
	localparam int MAX_TRIES       = 100000;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS*(MAX_GAP + PIPE_LAT + 1) + 100;

	logic        clk;
	logic        reset;
	logic        inStrobe;
	featureVec_t features;
	logic        outStrobe;
	classIdx_t   classIdx;
	act_t        classScore;
	classVec_t   scores;

	string       testName[NUM_TESTS];
	featureVec_t testVec[NUM_TESTS];
	int          testGap[NUM_TESTS];
	int          testClass[NUM_TESTS]; // -1 where only the model decides

	int          expTest[$]; // Oldest first
	int          expEdge[$];
	classVec_t   expScores[$];

	logic [31:0] lfsrState = 32'h83fe4d2a;
	int          cycleCnt  = 0;

	nnClassifier i_dut (
		.clk        (clk),
		.reset      (reset),
		.inStrobe   (inStrobe),
		.features   (features),
		.outStrobe  (outStrobe),
		.classIdx   (classIdx),
		.classScore (classScore),
		.scores     (scores)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	// ********************
	// Random source
	// ********************
	function automatic logic nextBit();
		logic b;
		b = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (b)
			lfsrState = lfsrState ^ 32'h80200003;
		return b;
	endfunction

	function automatic int randomBits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++)
			v = (v << 1) | int'(nextBit());
		return v;
	endfunction

	function automatic featureVec_t randomVector();
		featureVec_t v;
		for (int k = 0; k < NUM_FEATURES*DATA_W; k++)
			v[k] = nextBit();
		return v;
	endfunction

	// ********************
	// Reference model
	// ********************
	function automatic int toInt(input logic [DATA_W-1:0] b);
		return int'($signed(b));
	endfunction

	// Low byte of the exact sum is the same as truncated products wrapped
	function automatic act_t wrapRelu(input int acc);
		logic [DATA_W-1:0] w;
		w = acc[DATA_W-1:0];
		return w[DATA_W-1] ? act_t'(0) : act_t'(w);
	endfunction

	function automatic classVec_t predictScores(input featureVec_t v);
		act_t      hid[NUM_HIDDEN];
		int        acc;
		classVec_t s;
		for (int n = 0; n < NUM_HIDDEN; n++)
		begin
			acc = toInt(HIDDEN_BIASES[n*DATA_W +: DATA_W]);
			for (int i = 0; i < NUM_FEATURES; i++)
				acc += toInt(v[i*DATA_W +: DATA_W])
					* toInt(HIDDEN_WEIGHTS[(n*NUM_FEATURES + i)*DATA_W +: DATA_W]);
			hid[n] = wrapRelu(acc);
		end
		for (int c = 0; c < NUM_CLASSES; c++)
		begin
			acc = toInt(OUT_BIASES[c*DATA_W +: DATA_W]);
			for (int h = 0; h < NUM_HIDDEN; h++)
				acc += int'(hid[h]) * toInt(OUT_WEIGHTS[(c*NUM_HIDDEN + h)*DATA_W +: DATA_W]);
			s[c*DATA_W +: DATA_W] = wrapRelu(acc);
		end
		return s;
	endfunction

	function automatic int pickClass(input classVec_t s);
		int best;
		best = 0;
		for (int c = 1; c < NUM_CLASSES; c++)
			if (toInt(s[c*DATA_W +: DATA_W]) > toInt(s[best*DATA_W +: DATA_W]))
				best = c; // Ties keep the lower index
		return best;
	endfunction

	function automatic logic hasTopTie(input classVec_t s);
		int best;
		int top;
		best = pickClass(s);
		top  = toInt(s[best*DATA_W +: DATA_W]);
		for (int c = best + 1; c < NUM_CLASSES; c++)
			if (top > 0 && toInt(s[c*DATA_W +: DATA_W]) == top)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	// ********************
	// Stimulus table
	// ********************
	task automatic setEntry(input int idx, input string name, input featureVec_t vec,
		input int gap, input int cls);
		testName[idx]  = name;
		testVec[idx]   = vec;
		testGap[idx]   = gap;
		testClass[idx] = cls;
	endtask

	task automatic findVector(input logic wantTie, output featureVec_t v);
		classVec_t s;
		for (int k = 0; k < MAX_TRIES; k++)
		begin
			v = randomVector();
			s = predictScores(v);
			if (wantTie ? hasTopTie(s) : (s == '0))
				return;
		end
		abortRun("No random vector met the search condition for a fixed entry");
	endtask

	task automatic buildTable();
		featureVec_t v;
		setEntry(0, "zero_vector", '0, MAX_GAP, 0); // Scores 100, 0, 95
		setEntry(1, "wrap_max", {NUM_FEATURES{8'h7f}}, MAX_GAP, -1);
		setEntry(2, "wrap_min", {NUM_FEATURES{8'h80}}, MAX_GAP, -1);
		findVector(1'b0, v);
		setEntry(3, "all_negative", v, MAX_GAP, 0);
		findVector(1'b1, v);
		setEntry(4, "tie_low_index", v, MAX_GAP, -1);
		for (int k = 0; k < NUM_RANDOM; k++)
		begin
			setEntry(NUM_FIXED + k, $sformatf("back_to_back_%0d", k), randomVector(), 0, -1);
			v = randomVector();
			setEntry(NUM_FIXED + NUM_RANDOM + k, $sformatf("mixed_gap_%0d", k), v,
				randomBits(3) % 6, -1);
		end
	endtask

	task automatic applyEntry(input int t);
		features = testVec[t];
		inStrobe = 1'b1;
		expTest.push_back(t);
		expEdge.push_back(cycleCnt + PIPE_LAT);
		expScores.push_back(predictScores(testVec[t]));
	endtask

	// ********************
	// Checker
	// ********************
	task automatic checkOutput();
		int        t;
		int        edgeWant;
		int        idxWant;
		classVec_t want;
		assert (expTest.size() != 0)
		else
			abortRun("outStrobe pulsed although no vector was outstanding");
		t        = expTest.pop_front();
		edgeWant = expEdge.pop_front();
		want     = expScores.pop_front();
		idxWant  = pickClass(want);
		assert (cycleCnt == edgeWant)
		else
			abortRun($sformatf("FAIL %s latency: expected cycle %0d, actual cycle %0d",
				testName[t], edgeWant, cycleCnt));
		assert (scores == want)
		else
			abortRun($sformatf("FAIL %s scores: expected %h, actual %h",
				testName[t], want, scores));
		assert (int'(classIdx) == idxWant)
		else
			abortRun($sformatf("FAIL %s classIdx: expected %0d, actual %0d",
				testName[t], idxWant, classIdx));
		assert (int'(classScore) == toInt(want[idxWant*DATA_W +: DATA_W]))
		else
			abortRun($sformatf("FAIL %s classScore: expected %0d, actual %0d",
				testName[t], toInt(want[idxWant*DATA_W +: DATA_W]), classScore));
		if (testClass[t] >= 0)
			assert (int'(classIdx) == testClass[t])
			else
				abortRun($sformatf("FAIL %s hand class: expected %0d, actual %0d",
					testName[t], testClass[t], classIdx));
	endtask

	initial
	begin
		forever
		begin
			@(negedge clk);
			if (outStrobe === 1'b1)
				checkOutput();
			else if (cycleCnt > 0)
			begin
				assert (outStrobe === 1'b0) // Low from the first reset edge on
				else
					abortRun("outStrobe was unknown after the first clock edge");
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abortRun("Timeout: DUT outputs stopped arriving before every vector was checked");
	end

	// ********************
	// Main sequence
	// ********************
	initial
	begin
		reset    = 1'b1;
		inStrobe = 1'b0;
		features = '0;
		buildTable();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (10) @(negedge clk); // Idle, nothing may come out
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			applyEntry(t);
			@(negedge clk);
			inStrobe = 1'b0;
			repeat (testGap[t]) @(negedge clk);
		end
		while (expTest.size() != 0)
			@(negedge clk);
		repeat (2*PIPE_LAT) @(negedge clk); // Watch for stray strobes
		@(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/nnPkg.sv
hdl/neuronNode.sv
hdl/denseLayer.sv
hdl/classArgmax.sv
hdl/nnClassifier.sv
sim/nnClassifierTb.sv

// ==== Makefile ====
# Verilator build and run for the MLP classifier testbench

VERILATOR ?= verilator
TOP       ?= nnClassifierTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
